// File: build.f
rtl/xge_rx_pkg.sv
rtl/xge_rx_pad_aligner.sv
rtl/axis_packet_gate.sv
rtl/xge_rx_top.sv
verification/xge_rx_tb.sv

// File: rtl/axis_packet_gate.sv
// Whole-frame store-and-forward buffer.
// Releases a frame only after its clean tlast is stored. Errored and
// oversized frames are rewound out of memory and never reach the output.

`timescale 1ns/1ps

module axis_packet_gate (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             clear,
   input  logic [xge_rx_pkg::DATA_W-1:0]    pad_tdata,
   input  logic [xge_rx_pkg::OCC_W:0]       pad_tuser,
   input  logic                             pad_tlast,
   input  logic                             pad_tvalid,
   output logic                             pad_tready,
   output logic [xge_rx_pkg::DATA_W-1:0]    out_tdata,
   output logic [xge_rx_pkg::OCC_W-1:0]     out_tuser,
   output logic                             out_tlast,
   output logic                             out_tvalid,
   input  logic                             out_tready
);

   // Entry holds last, occupancy and data
   logic [xge_rx_pkg::DATA_W+xge_rx_pkg::OCC_W:0] mem [2**xge_rx_pkg::GATE_ADDR_W];

   logic [xge_rx_pkg::GATE_ADDR_W-1:0] wr_ptr;
   logic [xge_rx_pkg::GATE_ADDR_W-1:0] wr_next;
   logic [xge_rx_pkg::GATE_ADDR_W-1:0] commit_ptr;
   logic [xge_rx_pkg::GATE_ADDR_W-1:0] rd_ptr;

   // Discarding the rest of an overflowed frame
   logic drop;

   logic full;
   logic in_xfer;
   logic in_err_last;
   logic wr_en;
   logic rd_en;

   // Fill levels seen from the reader
   logic [xge_rx_pkg::GATE_ADDR_W-1:0] commit_lvl;
   logic [xge_rx_pkg::GATE_ADDR_W-1:0] write_lvl;

   assign wr_next = wr_ptr + 1'b1;

   // One slot stays free so full and empty differ
   assign full = (wr_next == rd_ptr);

   // Stall only at a frame start with the memory full of committed frames
   // Mid-frame overflow is handled by the drop path instead
   assign pad_tready = !(full && !drop && (wr_ptr == commit_ptr));

   assign in_xfer     = pad_tvalid && pad_tready;
   assign in_err_last = pad_tlast && pad_tuser[xge_rx_pkg::OCC_W];
   assign wr_en       = in_xfer && !drop && !in_err_last && !full;

   // Only committed words are released
   assign rd_en = (rd_ptr != commit_ptr) && (!out_tvalid || out_tready);

   // Write side
   always_ff @(posedge clk) begin
      if (rst || clear) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
         drop       <= 1'b0;
      end else if (in_xfer) begin
         if (drop) begin
            // Tail of an oversized frame, tlast ends the drop
            if (pad_tlast) begin
               drop <= 1'b0;
            end
         end else if (in_err_last) begin
            // Bad frame, rewind to the last clean end
            wr_ptr <= commit_ptr;
         end else if (full) begin
            // Frame is too large for the buffer
            wr_ptr <= commit_ptr;
            drop   <= !pad_tlast;
         end else begin
            wr_ptr <= wr_next;
            // Clean tlast makes the frame readable
            if (pad_tlast) begin
               commit_ptr <= wr_next;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= {pad_tlast, pad_tuser[xge_rx_pkg::OCC_W-1:0], pad_tdata};
      end
   end

   // Read side with one output register
   always_ff @(posedge clk) begin
      if (rst || clear) begin
         rd_ptr     <= '0;
         out_tvalid <= 1'b0;
      end else if (rd_en) begin
         rd_ptr     <= rd_ptr + 1'b1;
         out_tvalid <= 1'b1;
      end else if (out_tready) begin
         out_tvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         {out_tlast, out_tuser, out_tdata} <= mem[rd_ptr];
      end
   end

   assign commit_lvl = commit_ptr - rd_ptr;
   assign write_lvl  = wr_ptr - rd_ptr;

   // Reader stays behind the commit point, which stays behind the writer
   a_rd_behind_commit : assert property (
      @(posedge clk) disable iff (rst)
      commit_lvl <= write_lvl
   ) else $error("read pointer passed the committed pointer");

   // Output held steady under back-pressure
   a_out_stable : assert property (
      @(posedge clk) disable iff (rst)
      (out_tvalid && !out_tready && !clear)
         |=> (out_tvalid && $stable(out_tdata) && $stable(out_tuser) && $stable(out_tlast))
   ) else $error("out_* changed while out_tvalid high and out_tready low");

endmodule

// File: rtl/xge_rx_pad_aligner.sv
// Pad aligner for the 10 GbE receive path.
// Shifts each MAC frame by 6 bytes behind a label octet and 5 zero bytes.
// The MAC cannot be stalled, so a lost word or a valid drop mid-frame
// ends the frame with an error tlast and the FSM waits for the next sof.

`timescale 1ns/1ps

module xge_rx_pad_aligner #(
   parameter logic [xge_rx_pkg::LABEL_W-1:0] label = '0
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             clear,
   input  logic [xge_rx_pkg::DATA_W-1:0]    mac_data,
   input  logic [xge_rx_pkg::OCC_W-1:0]     mac_occ,
   input  logic                             mac_sof,
   input  logic                             mac_eof,
   input  logic                             mac_err,
   input  logic                             mac_valid,
   output logic [xge_rx_pkg::DATA_W-1:0]    pad_tdata,
   output logic [xge_rx_pkg::OCC_W:0]       pad_tuser,
   output logic                             pad_tlast,
   output logic                             pad_tvalid,
   input  logic                             pad_tready
);

   xge_rx_pkg::aligner_state_t state;

   // Low 6 bytes of the previous MAC word
   logic [xge_rx_pkg::PAD_BYTES*8-1:0] hold_q;

   // Error flag and occupancy owed to the flush word
   logic                           flush_err;
   logic [xge_rx_pkg::OCC_W-1:0]   flush_occ;

   // Byte count of the current MAC word, 8 when the code is 0
   logic [xge_rx_pkg::OCC_W:0] last_bytes;

   // Byte count plus pad, low bits give the output code
   int                           occ_sum;
   logic [xge_rx_pkg::OCC_W-1:0] occ_next;

   // Last word fits in the current output word, no flush needed
   logic close_now;

   // Word on the link was not taken
   logic lost;
   logic abort;

   assign last_bytes = {mac_occ == '0, mac_occ};
   assign occ_sum    = int'(last_bytes) + xge_rx_pkg::PAD_BYTES;
   assign occ_next   = occ_sum[xge_rx_pkg::OCC_W-1:0];
   assign close_now  = occ_sum <= xge_rx_pkg::DATA_W / 8;

   assign lost = pad_tvalid && !pad_tready;

   // Abandon the frame on a lost word, or when the MAC drops valid mid-frame
   // Error hold has its own exit below
   assign abort = (state != xge_rx_pkg::ST_ERROR_HOLD) &&
                  (lost || (state == xge_rx_pkg::ST_IN_USE && !mac_valid));

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         state      <= xge_rx_pkg::ST_EMPTY;
         pad_tvalid <= 1'b0;
         pad_tlast  <= 1'b0;
      end else begin
         // Words are single-cycle pulses unless held below
         pad_tvalid <= 1'b0;
         pad_tlast  <= 1'b0;

         if (abort) begin
            // Error tlast makes the gate rewind the partial frame
            state      <= xge_rx_pkg::ST_ERROR_HOLD;
            pad_tvalid <= 1'b1;
            pad_tlast  <= 1'b1;
            pad_tuser  <= {1'b1, {xge_rx_pkg::OCC_W{1'b0}}};
         end else begin
            case (state)
               xge_rx_pkg::ST_EMPTY: begin
                  // Label, zero field and the top 2 bytes of the first MAC word
                  hold_q    <= mac_data[xge_rx_pkg::PAD_BYTES*8-1:0];
                  pad_tdata <= {label,
                                {xge_rx_pkg::PAD_ZERO_W{1'b0}},
                                mac_data[xge_rx_pkg::DATA_W-1:xge_rx_pkg::PAD_BYTES*8]};
                  pad_tuser <= '0;
                  // Anything but sof is the tail of a dropped frame
                  if (mac_valid && mac_sof) begin
                     pad_tvalid <= 1'b1;
                     state      <= xge_rx_pkg::ST_IN_USE;
                  end
               end

               xge_rx_pkg::ST_IN_USE: begin
                  // Held bytes on top, new top 2 bytes below
                  hold_q     <= mac_data[xge_rx_pkg::PAD_BYTES*8-1:0];
                  pad_tdata  <= {hold_q,
                                 mac_data[xge_rx_pkg::DATA_W-1:xge_rx_pkg::PAD_BYTES*8]};
                  pad_tvalid <= 1'b1;
                  pad_tuser  <= '0;
                  // MAC error forces the end of frame too
                  if (mac_eof || mac_err) begin
                     if (close_now) begin
                        // 1 or 2 bytes in the last word
                        pad_tlast <= 1'b1;
                        pad_tuser <= {mac_err, occ_next};
                        state     <= xge_rx_pkg::ST_EMPTY;
                     end else begin
                        // Same code, since +6 and -2 agree modulo 8
                        flush_err <= mac_err;
                        flush_occ <= occ_next;
                        state     <= xge_rx_pkg::ST_FLUSH;
                     end
                  end
               end

               xge_rx_pkg::ST_FLUSH: begin
                  // Interframe gap means no sof can arrive here
                  pad_tdata  <= {hold_q,
                                 {(xge_rx_pkg::DATA_W - xge_rx_pkg::PAD_BYTES*8){1'b0}}};
                  pad_tuser  <= {flush_err, flush_occ};
                  pad_tvalid <= 1'b1;
                  pad_tlast  <= 1'b1;
                  state      <= xge_rx_pkg::ST_EMPTY;
               end

               xge_rx_pkg::ST_ERROR_HOLD: begin
                  // MAC data meanwhile is dropped
                  if (pad_tready) begin
                     state <= xge_rx_pkg::ST_EMPTY;
                  end else begin
                     pad_tvalid <= 1'b1;
                     pad_tlast  <= 1'b1;
                  end
               end

               default: begin
                  state <= xge_rx_pkg::ST_EMPTY;
               end
            endcase
         end
      end
   end

   // tlast never travels alone
   a_tlast_with_valid : assert property (
      @(posedge clk) disable iff (rst)
      pad_tlast |-> pad_tvalid
   ) else $error("pad_tlast high without pad_tvalid");

   // MAC never puts sof and eof on the same word
   a_no_sof_eof : assert property (
      @(posedge clk) disable iff (rst)
      mac_valid |-> !(mac_sof && mac_eof)
   ) else $error("mac_sof and mac_eof seen together");

   // Forced error word stays until the gate takes it
   a_error_hold : assert property (
      @(posedge clk) disable iff (rst)
      (state == xge_rx_pkg::ST_ERROR_HOLD && !pad_tready && !clear)
         |=> (state == xge_rx_pkg::ST_ERROR_HOLD && pad_tvalid && pad_tlast)
   ) else $error("aligner left error hold without pad_tready");

endmodule

// File: rtl/xge_rx_pkg.sv
// Shared constants and types for the 10 GbE receive path.
// Every RTL file pulls what it needs by scoped name from here.

package xge_rx_pkg;

   // Stream and MAC word width
   localparam int DATA_W = 64;

   // Occupancy code width
   // Code 0 means 8 valid bytes, 1 to 7 give the byte count
   localparam int OCC_W = 3;

   // Bytes pushed in front of every frame
   localparam int PAD_BYTES = 6;

   // Zero field between the label and the first frame bytes
   localparam int PAD_ZERO_W = 40;

   // Label octet in the top byte of the first word
   localparam int LABEL_W = 8;

   // Gate memory address width, 256 words
   // One slot stays free, so a frame may use 255 words at most
   localparam int GATE_ADDR_W = 8;

   // Aligner FSM
   typedef enum logic [1:0] {
      ST_EMPTY,       // waiting for sof
      ST_IN_USE,      // mid-frame
      ST_FLUSH,       // one more word of held bytes is owed
      ST_ERROR_HOLD   // forced error tlast waiting for ready
   } aligner_state_t;

endpackage

// File: rtl/xge_rx_top.sv
// Receive path top level for one 10 GbE port.
// MAC strobes go into the pad aligner, whole clean frames leave the gate.
// The label parameter tags frames with the ingress port.

`timescale 1ns/1ps

module xge_rx_top #(
   parameter logic [xge_rx_pkg::LABEL_W-1:0] label = '0
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             clear,
   input  logic [xge_rx_pkg::DATA_W-1:0]    mac_data,
   input  logic [xge_rx_pkg::OCC_W-1:0]     mac_occ,
   input  logic                             mac_sof,
   input  logic                             mac_eof,
   input  logic                             mac_err,
   input  logic                             mac_valid,
   output logic [xge_rx_pkg::DATA_W-1:0]    out_tdata,
   output logic [xge_rx_pkg::OCC_W-1:0]     out_tuser,
   output logic                             out_tlast,
   output logic                             out_tvalid,
   input  logic                             out_tready
);

   // Aligner to gate link, tuser carries error flag over occupancy
   logic [xge_rx_pkg::DATA_W-1:0] pad_tdata;
   logic [xge_rx_pkg::OCC_W:0]    pad_tuser;
   logic                          pad_tlast;
   logic                          pad_tvalid;
   logic                          pad_tready;

   xge_rx_pad_aligner #(
      .label (label)
   ) i_pad_aligner (
      .clk        (clk),
      .rst        (rst),
      .clear      (clear),
      .mac_data   (mac_data),
      .mac_occ    (mac_occ),
      .mac_sof    (mac_sof),
      .mac_eof    (mac_eof),
      .mac_err    (mac_err),
      .mac_valid  (mac_valid),
      .pad_tdata  (pad_tdata),
      .pad_tuser  (pad_tuser),
      .pad_tlast  (pad_tlast),
      .pad_tvalid (pad_tvalid),
      .pad_tready (pad_tready)
   );

   axis_packet_gate i_packet_gate (
      .clk        (clk),
      .rst        (rst),
      .clear      (clear),
      .pad_tdata  (pad_tdata),
      .pad_tuser  (pad_tuser),
      .pad_tlast  (pad_tlast),
      .pad_tvalid (pad_tvalid),
      .pad_tready (pad_tready),
      .out_tdata  (out_tdata),
      .out_tuser  (out_tuser),
      .out_tlast  (out_tlast),
      .out_tvalid (out_tvalid),
      .out_tready (out_tready)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the receive-path testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Something failed"

verilator --binary --timing --assert -Wno-fatal \
   -f build.f --top-module xge_rx_tb --Mdir obj_dir -o xge_rx_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/xge_rx_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status"
   exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
   echo "Simulation ended without a pass report"
   exit 1
fi
exit 0

// File: verification/xge_rx_tb.sv
// Testbench for the 10 GbE receive path.
// Sends MAC frames and checks every output word against a queue of expected
// padded words with concurrent assertions. Covers padding, MAC errors,
// valid drops, back-pressure, oversized frames, reset and clear.

`timescale 1ns/1ps

module xge_rx_tb;

   localparam int dw = xge_rx_pkg::DATA_W;
   localparam int ow = xge_rx_pkg::OCC_W;
   localparam logic [xge_rx_pkg::LABEL_W-1:0] label_value = 8'hA5;
   localparam int frame_count = 37;
   localparam int watchdog_cycles = frame_count * 300 + 2000;
   localparam int ready_low = 0;
   localparam int ready_random = 1;

   logic          clk;
   logic          rst;
   logic          clear;
   logic [dw-1:0] mac_data;
   logic [ow-1:0] mac_occ;
   logic          mac_sof;
   logic          mac_eof;
   logic          mac_err;
   logic          mac_valid;
   logic [dw-1:0] out_tdata;
   logic [ow-1:0] out_tuser;
   logic          out_tlast;
   logic          out_tvalid;
   logic          out_tready;

   logic [15:0]   lfsr_q;
   int            ready_mode;
   // Expected words, each {last, occupancy, data}
   logic [dw+ow:0] exp_q[$];
   logic [dw+ow:0] head_q;
   logic           head_have;
   logic           xfer;

   xge_rx_top #(
      .label (label_value)
   ) i_xge_rx_top (
      .clk        (clk),
      .rst        (rst),
      .clear      (clear),
      .mac_data   (mac_data),
      .mac_occ    (mac_occ),
      .mac_sof    (mac_sof),
      .mac_eof    (mac_eof),
      .mac_err    (mac_err),
      .mac_valid  (mac_valid),
      .out_tdata  (out_tdata),
      .out_tuser  (out_tuser),
      .out_tlast  (out_tlast),
      .out_tvalid (out_tvalid),
      .out_tready (out_tready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // 16-bit Galois LFSR, maximal length taps
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic int take_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         v = (v << 1) | int'(lfsr_q[0]);
         lfsr_q = lfsr_next(lfsr_q);
      end
      return v;
   endfunction

   // Valid bytes sit at the top of the word, code 0 means all 8
   function automatic logic [dw-1:0] byte_mask(input logic [ow-1:0] occ);
      int          n;
      logic [dw-1:0] m;
      n = (occ == '0) ? 8 : int'(occ);
      m = '0;
      for (int i = 0; i < n; i++) begin
         m[dw-1-8*i -: 8] = 8'hFF;
      end
      return m;
   endfunction

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Something failed");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic drive_idle();
      mac_data  = '0;
      mac_occ   = '0;
      mac_sof   = 1'b0;
      mac_eof   = 1'b0;
      mac_err   = 1'b0;
      mac_valid = 1'b0;
   endtask

   // Next edge plus 1 ns, consumer ready redrawn here
   task automatic tick();
      @(posedge clk);
      #1;
      if (ready_mode == ready_random) begin
         // Takes about three words in four
         out_tready = (take_bits(2) != 0);
      end else begin
         out_tready = 1'b0;
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0 || out_tvalid) begin
         tick();
      end
   endtask

   // Sends one frame; a kept frame has its padded words queued first
   // drop_before below 0 means valid stays high for the whole frame
   task automatic send_frame(input int nbytes, input bit keep, input bit bad_end,
                             input int drop_before);
      logic [7:0]    body[$];
      logic [7:0]    padded[$];
      logic [dw-1:0] word;
      logic [ow-1:0] occ;
      logic          is_last;
      int            n_words;
      int            n_mac;
      for (int i = 0; i < nbytes; i++) begin
         body.push_back(8'(take_bits(8)));
      end
      // Keep the gate far from full while the consumer stalls at random
      if (ready_mode == ready_random) begin
         while (exp_q.size() > 64) begin
            tick();
         end
      end
      if (keep) begin
         // Label, 5 zero bytes, then the frame
         padded.push_back(label_value);
         repeat (xge_rx_pkg::PAD_ZERO_W / 8) begin
            padded.push_back(8'h00);
         end
         foreach (body[i]) begin
            padded.push_back(body[i]);
         end
         n_words = (padded.size() + 7) / 8;
         for (int w = 0; w < n_words; w++) begin
            word = '0;
            for (int b = 0; b < 8; b++) begin
               if (8 * w + b < padded.size()) begin
                  word[dw-1-8*b -: 8] = padded[8*w+b];
               end
            end
            is_last = (w == n_words - 1);
            occ     = is_last ? 3'(padded.size() % 8) : 3'd0;
            exp_q.push_back({is_last, occ, word});
         end
      end
      n_mac = (nbytes + 7) / 8;
      for (int m = 0; m < n_mac; m++) begin
         if (m == drop_before) begin
            // MAC loses valid for two cycles in mid-frame
            drive_idle();
            tick();
            tick();
         end
         word = '0;
         for (int b = 0; b < 8; b++) begin
            if (8 * m + b < nbytes) begin
               word[dw-1-8*b -: 8] = body[8*m+b];
            end
         end
         mac_data  = word;
         mac_valid = 1'b1;
         mac_sof   = (m == 0);
         mac_eof   = (m == n_mac - 1);
         mac_err   = bad_end && (m == n_mac - 1);
         mac_occ   = (m == n_mac - 1) ? 3'(nbytes % 8) : 3'd0;
         tick();
      end
      // Interframe gap of one or two cycles
      drive_idle();
      repeat (1 + take_bits(1)) begin
         tick();
      end
   endtask

   assign xfer = out_tvalid && out_tready;

   // Head register follows the queue front after each edge
   always @(posedge clk) begin
      if (!rst && xfer && exp_q.size() > 0) begin
         void'(exp_q.pop_front());
      end
      head_have <= (exp_q.size() > 0);
      if (exp_q.size() > 0) begin
         head_q <= exp_q[0];
      end
   end

   a_word_expected : assert property (
      @(posedge clk) disable iff (rst)
      xfer |-> head_have
   ) else report_failure("Output word arrived while no frame was expected");

   a_out_tdata : assert property (
      @(posedge clk) disable iff (rst)
      (xfer && head_have) |->
         ((out_tdata & byte_mask(head_q[dw+ow-1:dw])) ==
          (head_q[dw-1:0] & byte_mask(head_q[dw+ow-1:dw])))
   ) else report_failure($sformatf("ERROR out_tdata expected %h actual %h",
                                   $sampled(head_q[dw-1:0]), $sampled(out_tdata)));

   a_out_tuser : assert property (
      @(posedge clk) disable iff (rst)
      (xfer && head_have) |-> (out_tuser == head_q[dw+ow-1:dw])
   ) else report_failure($sformatf("ERROR out_tuser expected %h actual %h",
                                   $sampled(head_q[dw+ow-1:dw]), $sampled(out_tuser)));

   a_out_tlast : assert property (
      @(posedge clk) disable iff (rst)
      (xfer && head_have) |-> (out_tlast == head_q[dw+ow])
   ) else report_failure($sformatf("ERROR out_tlast expected %h actual %h",
                                   $sampled(head_q[dw+ow]), $sampled(out_tlast)));

   // Output stays idle through reset
   a_idle_in_reset : assert property (
      @(posedge clk) (rst && $past(rst)) |-> !out_tvalid
   ) else report_failure($sformatf("ERROR out_tvalid expected 0 actual %h in reset",
                                   $sampled(out_tvalid)));

   a_clear_empties : assert property (
      @(posedge clk) disable iff (rst)
      clear |=> !out_tvalid
   ) else report_failure($sformatf("ERROR out_tvalid expected 0 actual %h after clear",
                                   $sampled(out_tvalid)));

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      report_failure("Timeout: the frames did not drain in time");
   end

   initial begin
      lfsr_q     = 16'd35925;
      ready_mode = ready_low;
      rst        = 1'b1;
      clear      = 1'b0;
      out_tready = 1'b0;
      drive_idle();
      repeat (8) @(posedge clk);
      #1;
      rst        = 1'b0;
      ready_mode = ready_random;
      tick();

      // Final MAC word with 1 to 8 bytes, then random lengths
      for (int c = 1; c <= 8; c++) begin
         send_frame(8 * (1 + take_bits(3)) + c, 1'b1, 1'b0, -1);
      end
      repeat (6) begin
         send_frame(9 + take_bits(7), 1'b1, 1'b0, -1);
      end

      // MAC error at eof, then a clean frame
      send_frame(40 + take_bits(5), 1'b0, 1'b1, -1);
      send_frame(9 + take_bits(6), 1'b1, 1'b0, -1);

      // Valid drop between clean frames
      send_frame(30 + take_bits(4), 1'b1, 1'b0, -1);
      send_frame(48 + take_bits(4), 1'b0, 1'b0, 3);
      send_frame(9 + take_bits(6), 1'b1, 1'b0, -1);

      // Consumer stalled: 6 frames of 40 words, one word waits in the output
      // register, so 16 more words fill the gate exactly
      wait_drain();
      ready_mode = ready_low;
      repeat (6) begin
         send_frame(314, 1'b1, 1'b0, -1);
      end
      // Overflows in mid-frame
      send_frame(314, 1'b0, 1'b0, -1);
      send_frame(122, 1'b1, 1'b0, -1);
      // Arrive while the gate is full
      send_frame(60, 1'b0, 1'b0, -1);
      send_frame(100, 1'b0, 1'b0, -1);
      ready_mode = ready_random;
      wait_drain();
      send_frame(9 + take_bits(6), 1'b1, 1'b0, -1);

      // 261 padded words, more than the gate holds
      wait_drain();
      send_frame(2080, 1'b0, 1'b0, -1);
      send_frame(9 + take_bits(6), 1'b1, 1'b0, -1);

      // Two buffered frames wiped by a clear pulse
      wait_drain();
      ready_mode = ready_low;
      send_frame(50, 1'b0, 1'b0, -1);
      send_frame(70, 1'b0, 1'b0, -1);
      repeat (8) begin
         tick();
      end
      clear = 1'b1;
      tick();
      clear      = 1'b0;
      ready_mode = ready_random;
      repeat (4) begin
         tick();
      end
      send_frame(9 + take_bits(6), 1'b1, 1'b0, -1);

      // Reset pulse while a buffered frame waits at the output
      wait_drain();
      ready_mode = ready_low;
      send_frame(60, 1'b0, 1'b0, -1);
      repeat (8) begin
         tick();
      end
      rst = 1'b1;
      repeat (4) begin
         tick();
      end
      rst        = 1'b0;
      ready_mode = ready_random;
      tick();
      send_frame(9 + take_bits(6), 1'b1, 1'b0, -1);

      wait_drain();
      repeat (20) begin
         tick();
      end
      if (exp_q.size() == 0 && !out_tvalid) begin
         $display("Everything OK");
         $finish;
      end else begin
         report_failure("Output still busy after the last frame");
      end
   end

endmodule
